// ==== flist.f ====
hw/led_matrix_pkg.sv
hw/axi_pixel_write.sv
hw/framebuffer.sv
hw/matrix_scan.sv
hw/pixel_split.sv
hw/hub75_output.sv
hw/led_matrix_top.sv
testbench/tb_led_matrix_sva.sv
testbench/tb_led_matrix.sv

// ==== hw/axi_pixel_write.sv ====
// --------------------
// AXI4-Lite write slave
// pixel writes to the framebuffer, one control register at ctrl_addr
// --------------------
`timescale 1ns/1ps

module axi_pixel_write (
    input  logic                                       clk_root,
    input  logic                                       reset,
    input  led_matrix_pkg::axi_aw_t                    aw,
    output logic                                       awready,
    input  led_matrix_pkg::axi_w_t                     w,
    output logic                                       wready,
    input  logic                                       bready,
    output led_matrix_pkg::axi_b_t                     b,
    output logic                                       pix_we,
    output logic [led_matrix_pkg::pix_index_bits-1:0]  pix_index,
    output led_matrix_pkg::pixel_t                     pix_data,
    output led_matrix_pkg::ctrl_t                      ctrl
);

    logic                  bvalid_q;
    logic                  accept;
    logic                  is_pixel;
    logic                  is_ctrl;
    led_matrix_pkg::ctrl_t ctrl_q;

    // AW and W are taken as one beat, so ready waits for both valids
    assign awready = !bvalid_q && aw.awvalid && w.wvalid;
    assign wready  = !bvalid_q && aw.awvalid && w.wvalid;
    assign accept  = aw.awvalid && w.wvalid && awready && wready;

    assign is_pixel = aw.awaddr < led_matrix_pkg::ctrl_addr;
    assign is_ctrl  = aw.awaddr == led_matrix_pkg::ctrl_addr;

    // a pixel spans the two low byte lanes
    assign pix_we    = accept && is_pixel && (&w.wstrb[1:0]);
    assign pix_index = aw.awaddr[2 +: led_matrix_pkg::pix_index_bits];
    assign pix_data  = w.wdata.pix.pixel;

    always_ff @(posedge clk_root) begin
        if (reset) begin
            bvalid_q <= 1'b0;
        end else if (accept) begin
            bvalid_q <= 1'b1;
        end else if (bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_root) begin
        if (reset) begin
            ctrl_q.pad          <= '0;
            ctrl_q.rgb_enable   <= '1;  // all colours on
            ctrl_q.plane_enable <= '1;  // all planes on
        end else if (accept && is_ctrl && w.wstrb[0]) begin
            // both enable fields sit in byte lane 0
            ctrl_q.rgb_enable   <= w.wdata.ctrl.rgb_enable;
            ctrl_q.plane_enable <= w.wdata.ctrl.plane_enable;
        end
    end

    assign ctrl     = ctrl_q;
    assign b.bvalid = bvalid_q;
    assign b.bresp  = 2'b00;  // always OKAY

endmodule

// ==== hw/framebuffer.sv ====
// --------------------
// two-bank pixel memory
// one bank per panel half, both read together at the same half-row and column
// --------------------
`timescale 1ns/1ps

module framebuffer #(
    parameter int panel_width  = led_matrix_pkg::default_panel_width,
    parameter int panel_height = led_matrix_pkg::default_panel_height
) (
    input  logic                                                   clk_root,
    input  logic                                                   pix_we,
    input  logic [led_matrix_pkg::pix_index_bits-1:0]              pix_index,
    input  led_matrix_pkg::pixel_t                                 pix_data,
    input  logic [$clog2(panel_height/led_matrix_pkg::num_halves)-1:0] rd_row,
    input  logic [$clog2(panel_width)-1:0]                         rd_col,
    output led_matrix_pkg::pixel_t [led_matrix_pkg::num_halves-1:0] rd_pixels
);

    localparam int half_pixels = panel_width * (panel_height / led_matrix_pkg::num_halves);
    localparam int addr_bits   = $clog2(half_pixels);
    localparam int bank_bits   = $clog2(led_matrix_pkg::num_halves);

    led_matrix_pkg::pixel_t mem [led_matrix_pkg::num_halves][half_pixels];

    logic [bank_bits-1:0] wr_bank;
    logic [addr_bits-1:0] wr_addr;
    logic [addr_bits-1:0] rd_addr;
    logic                 in_range;

    // row-major index, power-of-two panel, so the top row bit picks the bank
    assign wr_bank  = pix_index[addr_bits +: bank_bits];
    assign wr_addr  = pix_index[addr_bits-1:0];
    assign in_range = pix_index < (panel_width * panel_height);
    assign rd_addr  = {rd_row, rd_col};

    always_ff @(posedge clk_root) begin
        if (pix_we && in_range) begin
            mem[wr_bank][wr_addr] <= pix_data;
        end
        for (int h = 0; h < led_matrix_pkg::num_halves; h++) begin
            rd_pixels[h] <= mem[h][rd_addr];
        end
    end

endmodule

// ==== hw/hub75_output.sv ====
// --------------------
// HUB75 output stage
// one register stage for colour bits and strobes, row held through display
// --------------------
`timescale 1ns/1ps

module hub75_output (
    input  logic                                                  clk_root,
    input  logic                                                  reset,
    input  led_matrix_pkg::rgb_t [led_matrix_pkg::num_halves-1:0] rgb_in,
    input  logic                                                  shift_valid,
    input  logic                                                  latch,
    input  logic                                                  blank,
    input  logic [led_matrix_pkg::row_addr_bits-1:0]              row_addr,
    output led_matrix_pkg::hub75_t                                pins
);

    led_matrix_pkg::rgb_t [led_matrix_pkg::num_halves-1:0] rgb_q;
    logic                                     clk_q;
    logic                                     latch_q;
    logic                                     oe_n_q;
    logic [led_matrix_pkg::row_addr_bits-1:0] row_q;

    always_ff @(posedge clk_root) begin
        rgb_q <= rgb_in;
    end

    always_ff @(posedge clk_root) begin
        if (reset) begin
            clk_q   <= 1'b0;
            latch_q <= 1'b0;
            oe_n_q  <= 1'b1;  // dark until the first display
            row_q   <= '0;
        end else begin
            clk_q   <= shift_valid;
            latch_q <= latch;
            oe_n_q  <= blank | latch;
            if (oe_n_q) begin
                row_q <= row_addr;  // frozen once oe_n goes low
            end
        end
    end

    assign pins.rgb_top    = rgb_q[0];
    assign pins.rgb_bottom = rgb_q[1];
    assign pins.clk_pixel  = clk_q;
    assign pins.latch      = latch_q;
    assign pins.oe_n       = oe_n_q;
    assign pins.row_addr   = row_q;

endmodule

// ==== hw/led_matrix_pkg.sv ====
// --------------------
// led matrix shared types
// panel defaults, pixel and control words, AXI write channels and HUB75 pins
// --------------------
package led_matrix_pkg;

    localparam int default_panel_width = 32;
    localparam int default_panel_height = 16;
    localparam int default_base_ticks = 8;  // display cycles of plane 0

    localparam int color_bits = 4;  // BCM planes per colour
    localparam int plane_bits = $clog2(color_bits);
    localparam int num_halves = 2;
    localparam int row_addr_bits = 3;
    localparam int pix_index_bits = 9;  // pixel space below ctrl_addr, one word per pixel

    localparam logic [11:0] ctrl_addr = 12'h800;

    typedef struct packed {
        logic [color_bits-1:0] red;
        logic [color_bits-1:0] green;
        logic [color_bits-1:0] blue;
    } pixel_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    // rgb_enable bit order follows rgb_t, so [2] is red and [0] is blue
    typedef struct packed {
        logic [32-3-color_bits-1:0] pad;
        logic [2:0]                 rgb_enable;
        logic [color_bits-1:0]      plane_enable;
    } ctrl_t;

    typedef struct packed {
        logic [32-$bits(pixel_t)-1:0] pad;
        pixel_t                       pixel;
    } pixel_word_t;

    // one write word, read as a pixel or as the control register depending on address
    typedef union packed {
        pixel_word_t pix;
        ctrl_t       ctrl;
    } wdata_u;

    typedef struct packed {
        logic [11:0] awaddr;
        logic        awvalid;
    } axi_aw_t;

    typedef struct packed {
        wdata_u     wdata;
        logic [3:0] wstrb;
        logic       wvalid;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] bresp;
        logic       bvalid;
    } axi_b_t;

    typedef struct packed {
        rgb_t                     rgb_top;
        rgb_t                     rgb_bottom;
        logic                     clk_pixel;
        logic                     latch;
        logic                     oe_n;
        logic [row_addr_bits-1:0] row_addr;
    } hub75_t;

endpackage

// ==== hw/led_matrix_top.sv ====
// --------------------
// HUB75 matrix driver top
// AXI4-Lite pixel writes in, scanned panel pins out
// --------------------
`timescale 1ns/1ps

module led_matrix_top #(
    parameter int panel_width  = led_matrix_pkg::default_panel_width,
    parameter int panel_height = led_matrix_pkg::default_panel_height,
    parameter int base_ticks   = led_matrix_pkg::default_base_ticks
) (
    input  logic                    clk_root,
    input  logic                    reset,
    input  led_matrix_pkg::axi_aw_t aw,
    output logic                    awready,
    input  led_matrix_pkg::axi_w_t  w,
    output logic                    wready,
    input  logic                    bready,
    output led_matrix_pkg::axi_b_t  b,
    output led_matrix_pkg::hub75_t  pins
);

    localparam int col_bits = $clog2(panel_width);
    localparam int row_bits = $clog2(panel_height / led_matrix_pkg::num_halves);

    logic                                             pix_we;
    logic [led_matrix_pkg::pix_index_bits-1:0]        pix_index;
    led_matrix_pkg::pixel_t                           pix_data;
    led_matrix_pkg::ctrl_t                            ctrl;
    logic [row_bits-1:0]                              rd_row;
    logic [col_bits-1:0]                              rd_col;
    led_matrix_pkg::pixel_t [led_matrix_pkg::num_halves-1:0] rd_pixels;
    logic [led_matrix_pkg::plane_bits-1:0]            plane;
    logic                                             shift_valid;
    logic                                             latch;
    logic                                             blank;
    logic [led_matrix_pkg::row_addr_bits-1:0]         row_addr;
    led_matrix_pkg::rgb_t [led_matrix_pkg::num_halves-1:0] rgb;

    axi_pixel_write u_axi (
        .clk_root (clk_root),
        .reset    (reset),
        .aw       (aw),
        .awready  (awready),
        .w        (w),
        .wready   (wready),
        .bready   (bready),
        .b        (b),
        .pix_we   (pix_we),
        .pix_index(pix_index),
        .pix_data (pix_data),
        .ctrl     (ctrl)
    );

    framebuffer #(
        .panel_width (panel_width),
        .panel_height(panel_height)
    ) u_fb (
        .clk_root (clk_root),
        .pix_we   (pix_we),
        .pix_index(pix_index),
        .pix_data (pix_data),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .rd_pixels(rd_pixels)
    );

    matrix_scan #(
        .panel_width (panel_width),
        .panel_height(panel_height),
        .base_ticks  (base_ticks)
    ) u_scan (
        .clk_root   (clk_root),
        .reset      (reset),
        .rd_row     (rd_row),
        .rd_col     (rd_col),
        .plane      (plane),
        .shift_valid(shift_valid),
        .latch      (latch),
        .blank      (blank),
        .row_addr   (row_addr)
    );

    // index 0 is the top half, 1 the bottom half
    for (genvar h = 0; h < led_matrix_pkg::num_halves; h++) begin : g_split
        pixel_split u_split (
            .pixel(rd_pixels[h]),
            .plane(plane),
            .ctrl (ctrl),
            .rgb  (rgb[h])
        );
    end

    hub75_output u_out (
        .clk_root   (clk_root),
        .reset      (reset),
        .rgb_in     (rgb),
        .shift_valid(shift_valid),
        .latch      (latch),
        .blank      (blank),
        .row_addr   (row_addr),
        .pins       (pins)
    );

endmodule

// ==== hw/matrix_scan.sv ====
// --------------------
// scan sequencer
// column shift, blank, latch and BCM display time for each row and plane
// --------------------
`timescale 1ns/1ps

module matrix_scan #(
    parameter int panel_width  = led_matrix_pkg::default_panel_width,
    parameter int panel_height = led_matrix_pkg::default_panel_height,
    parameter int base_ticks   = led_matrix_pkg::default_base_ticks
) (
    input  logic                                                   clk_root,
    input  logic                                                   reset,
    output logic [$clog2(panel_height/led_matrix_pkg::num_halves)-1:0] rd_row,
    output logic [$clog2(panel_width)-1:0]                         rd_col,
    output logic [led_matrix_pkg::plane_bits-1:0]                  plane,
    output logic                                                   shift_valid,
    output logic                                                   latch,
    output logic                                                   blank,
    output logic [led_matrix_pkg::row_addr_bits-1:0]               row_addr
);

    localparam int half_height = panel_height / led_matrix_pkg::num_halves;
    localparam int col_bits    = $clog2(panel_width);
    localparam int row_bits    = $clog2(half_height);
    localparam int plane_bits  = led_matrix_pkg::plane_bits;
    localparam int tick_bits   = $clog2(base_ticks << (led_matrix_pkg::color_bits - 1)) + 1;

    localparam logic [1:0] st_shift   = 2'd0;
    localparam logic [1:0] st_blank   = 2'd1;
    localparam logic [1:0] st_latch   = 2'd2;
    localparam logic [1:0] st_display = 2'd3;

    logic [1:0]           state;
    logic                 phase;  // 0 = read issued, 1 = pixel clock
    logic [col_bits-1:0]  col;
    logic [tick_bits-1:0] ticks;

    assign rd_col      = col;
    assign shift_valid = (state == st_shift) && phase;
    assign blank       = (state == st_shift) || (state == st_blank);
    assign latch       = state == st_latch;

    always_ff @(posedge clk_root) begin
        if (reset) begin
            state    <= st_shift;
            phase    <= 1'b0;
            col      <= '0;
            rd_row   <= '0;
            plane    <= '0;
            row_addr <= '0;
            ticks    <= '0;
        end else begin
            case (state)
                st_shift: begin
                    phase <= !phase;
                    if (phase) begin
                        if (col == col_bits'(panel_width - 1)) begin
                            col   <= '0;
                            state <= st_blank;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                st_blank: state <= st_latch;
                st_latch: begin
                    state    <= st_display;
                    row_addr <= led_matrix_pkg::row_addr_bits'(rd_row);  // new row with oe_n low
                    ticks    <= tick_bits'((base_ticks << plane) - 1);
                end
                default: begin
                    if (ticks == '0) begin
                        state <= st_shift;
                        // planes inner, rows outer
                        if (plane == plane_bits'(led_matrix_pkg::color_bits - 1)) begin
                            plane <= '0;
                            if (rd_row == row_bits'(half_height - 1)) begin
                                rd_row <= '0;
                            end else begin
                                rd_row <= rd_row + 1'b1;
                            end
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        ticks <= ticks - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hw/pixel_split.sv ====
// --------------------
// bit-plane splitter
// picks the current plane bit per colour and applies the enables
// --------------------
`timescale 1ns/1ps

module pixel_split (
    input  led_matrix_pkg::pixel_t                pixel,
    input  logic [led_matrix_pkg::plane_bits-1:0] plane,
    input  led_matrix_pkg::ctrl_t                 ctrl,
    output led_matrix_pkg::rgb_t                  rgb
);

    logic plane_on;

    assign plane_on = ctrl.plane_enable[plane];  // whole plane can be muted

    assign rgb.r = pixel.red[plane] & ctrl.rgb_enable[2] & plane_on;
    assign rgb.g = pixel.green[plane] & ctrl.rgb_enable[1] & plane_on;
    assign rgb.b = pixel.blue[plane] & ctrl.rgb_enable[0] & plane_on;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the HUB75 matrix testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_led_matrix -f flist.f -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb 2>&1)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== testbench/tb_led_matrix.sv ====
// --------------------
// HUB75 matrix driver testbench
// random AXI writes against a panel model, pins checked line by line
// --------------------
`timescale 1ns/1ps

module tb_led_matrix;

    localparam int width           = led_matrix_pkg::default_panel_width;
    localparam int height          = led_matrix_pkg::default_panel_height;
    localparam int base_ticks      = led_matrix_pkg::default_base_ticks;
    localparam int planes          = led_matrix_pkg::color_bits;
    localparam int half_rows       = height / led_matrix_pkg::num_halves;
    localparam int lines_per_frame = half_rows * planes;
    localparam int ctrl_rounds     = 3;
    localparam int round_pixels    = 8;
    localparam int write_max       = 8;  // cycles, stall of up to 3 included

    logic                    clk_root = 1'b0;
    logic                    reset;
    led_matrix_pkg::axi_aw_t aw;
    logic                    awready;
    led_matrix_pkg::axi_w_t  w;
    logic                    wready;
    logic                    bready;
    led_matrix_pkg::axi_b_t  b;
    led_matrix_pkg::hub75_t  pins;

    logic [31:0] lfsr_state = 32'hb6b91506;

    led_matrix_pkg::pixel_t model_pix [width*height];
    led_matrix_pkg::ctrl_t  model_ctrl;
    logic                   pend_is_ctrl;  // write in flight, applied on the B handshake
    logic [8:0]             pend_index;
    logic [31:0]            pend_data;

    int  cycle = 0;
    int  first_clk_cycle = -1;
    int  col_count = 0;
    int  disp_count = 0;
    int  exp_row = 0;
    int  exp_plane = 0;
    int  lines_seen = 0;
    int  lines_checked = 0;
    bit  dirty = 1'b0;  // a write touched the current shift window
    bit  check_on = 1'b0;
    led_matrix_pkg::rgb_t top_s [width];
    led_matrix_pkg::rgb_t bot_s [width];

    led_matrix_top #(
        .panel_width (width),
        .panel_height(height),
        .base_ticks  (base_ticks)
    ) uut (
        .clk_root(clk_root),
        .reset   (reset),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .bready  (bready),
        .b       (b),
        .pins    (pins)
    );

    always #5 clk_root = ~clk_root;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // shift, blank, latch and display summed over all lines
    function automatic int frame_cycles();
        int total;
        total = 0;
        for (int p = 0; p < planes; p++) begin
            total += 2 * width + 2 + (base_ticks << p);
        end
        return total * half_rows;
    endfunction

    function automatic led_matrix_pkg::rgb_t expected_rgb(input led_matrix_pkg::pixel_t p,
                                                          input int pl);
        led_matrix_pkg::rgb_t bits;
        bits.r = p.red[pl] && model_ctrl.rgb_enable[2];
        bits.g = p.green[pl] && model_ctrl.rgb_enable[1];
        bits.b = p.blue[pl] && model_ctrl.rgb_enable[0];
        if (!model_ctrl.plane_enable[pl]) begin
            bits = '0;
        end
        return bits;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: %s: got %0h, expected %0h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic apply_pending();
        if (pend_is_ctrl) begin
            model_ctrl     = led_matrix_pkg::ctrl_t'(pend_data);
            model_ctrl.pad = '0;
        end else begin
            model_pix[pend_index] = pend_data[$bits(led_matrix_pkg::pixel_t)-1:0];
        end
    endtask

    task automatic line_end();
        check_equal(col_count, width, "pixel clocks per line");
        if (lines_seen == 0) begin
            check_equal(cycle - first_clk_cycle, 2 * width, "first latch after first pixel clock");
        end
        if (check_on && !dirty) begin
            for (int c = 0; c < width; c++) begin
                check_equal(top_s[c], expected_rgb(model_pix[exp_row*width + c], exp_plane),
                            $sformatf("rgb_top row %0d plane %0d col %0d", exp_row, exp_plane, c));
                check_equal(bot_s[c],
                            expected_rgb(model_pix[(exp_row + half_rows)*width + c], exp_plane),
                            $sformatf("rgb_bottom row %0d plane %0d col %0d",
                                      exp_row + half_rows, exp_plane, c));
            end
            lines_checked++;
        end
        lines_seen++;
        col_count = 0;
    endtask

    // pins sampled before the edge updates them
    always @(posedge clk_root) begin : monitor
        logic busy;
        if (!reset) begin
            busy = (aw.awvalid && awready && w.wvalid && wready) || b.bvalid;
            if (b.bvalid && bready) begin
                apply_pending();
            end
            cycle++;
            if (!pins.oe_n) begin
                disp_count++;
                dirty = busy;
                check_equal(pins.row_addr, exp_row, "row_addr during display");
            end else begin
                if (disp_count != 0) begin
                    check_equal(disp_count, base_ticks << exp_plane, "display length");
                    disp_count = 0;
                    if (exp_plane == planes - 1) begin
                        exp_plane = 0;
                        exp_row   = (exp_row + 1) % half_rows;
                    end else begin
                        exp_plane++;
                    end
                end
                dirty = dirty || busy;
                if (pins.clk_pixel) begin
                    if (first_clk_cycle < 0) begin
                        first_clk_cycle = cycle;
                    end
                    if (col_count < width) begin
                        top_s[col_count] = pins.rgb_top;
                        bot_s[col_count] = pins.rgb_bottom;
                    end
                    col_count++;
                end
                if (pins.latch) begin
                    line_end();
                end
            end
        end
    end

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic is_ctrl);
        int stall;
        @(negedge clk_root);
        stall        = int'(rand_bits(2));
        pend_is_ctrl = is_ctrl;
        pend_index   = addr[10:2];
        pend_data    = data;
        aw.awaddr    = addr;
        aw.awvalid   = 1'b1;
        w.wdata      = data;
        w.wstrb      = 4'hf;
        w.wvalid     = 1'b1;
        bready       = 1'b0;
        do @(posedge clk_root); while (!(awready && wready));
        @(negedge clk_root);
        aw.awvalid = 1'b0;
        w.wvalid   = 1'b0;
        check_equal(b.bvalid, 1, "bvalid after acceptance");
        repeat (stall) begin
            @(negedge clk_root);
            check_equal(b.bvalid, 1, "bvalid held while bready low");
        end
        bready = 1'b1;
        do @(posedge clk_root); while (!b.bvalid);
        check_equal(b.bresp, 0, "bresp OKAY");
    endtask

    task automatic wait_lines(input int n);
        int target;
        target = lines_seen + n;
        while (lines_seen < target) begin
            @(posedge clk_root);
        end
    endtask

    initial begin : stimulus
        led_matrix_pkg::ctrl_t cw;
        reset                   = 1'b1;
        aw                      = '0;
        w                       = '0;
        bready                  = 1'b0;
        model_ctrl              = '0;
        model_ctrl.rgb_enable   = '1;
        model_ctrl.plane_enable = '1;
        repeat (10) @(negedge clk_root);
        reset = 1'b0;
        check_equal(pins.oe_n, 1, "oe_n after reset");
        check_equal(pins.latch, 0, "latch after reset");
        check_equal(pins.row_addr, 0, "row_addr after reset");

        // every pixel gets a known value before lines are compared
        for (int i = 0; i < width * height; i++) begin
            axi_write(12'(i * 4), rand_bits($bits(led_matrix_pkg::pixel_t)), 1'b0);
        end
        check_on = 1'b1;
        wait_lines(lines_per_frame);

        for (int r = 0; r < ctrl_rounds; r++) begin
            cw                          = '0;
            cw.rgb_enable               = 3'(rand_bits(3));
            cw.rgb_enable[r % 3]        = 1'b0;  // at least one colour off
            cw.plane_enable             = 4'(rand_bits(planes));
            cw.plane_enable[(r+1) % planes] = 1'b0;
            axi_write(led_matrix_pkg::ctrl_addr, cw, 1'b1);
            for (int k = 0; k < round_pixels; k++) begin
                axi_write({1'b0, 9'(rand_bits(9)), 2'b00},
                          rand_bits($bits(led_matrix_pkg::pixel_t)), 1'b0);
            end
            wait_lines(lines_per_frame);
        end

        check_equal(lines_checked >= (ctrl_rounds + 1) * (lines_per_frame - 2), 1,
                    "clean lines compared");
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = 10 + (width * height + ctrl_rounds * (round_pixels + 1)) * write_max
                + (ctrl_rounds + 3) * frame_cycles();
        repeat (limit) @(posedge clk_root);
        $display("timeout: the test did not finish within %0d clock cycles", limit);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== testbench/tb_led_matrix_sva.sv ====
// --------------------
// bound checks on the AXI write handshake and the HUB75 strobes
// --------------------
`timescale 1ns/1ps

module tb_led_matrix_sva (
    input logic clk_root,
    input logic reset,
    input logic bvalid,
    input logic bready,
    input logic accept,
    input logic clk_pixel,
    input logic latch,
    input logic oe_n
);

    a_bvalid_hold: assert property (@(posedge clk_root) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    a_no_accept_pending: assert property (@(posedge clk_root) disable iff (reset)
        bvalid |-> !accept)
        else $error("write accepted while a response was pending");

    // panel already dark in the blank cycle before the latch
    a_latch_dark: assert property (@(posedge clk_root) disable iff (reset)
        latch |-> oe_n && $past(oe_n))
        else $error("latch high while the panel is lit");

    a_clk_dark: assert property (@(posedge clk_root) disable iff (reset)
        clk_pixel |-> oe_n)
        else $error("pixel clock during display");

endmodule

// AXI side, strobe ports tied inactive
bind axi_pixel_write tb_led_matrix_sva u_sva_axi (
    .clk_root (clk_root),
    .reset    (reset),
    .bvalid   (b.bvalid),
    .bready   (bready),
    .accept   (aw.awvalid && awready && w.wvalid && wready),
    .clk_pixel(1'b0),
    .latch    (1'b0),
    .oe_n     (1'b1)
);

// pin side, handshake ports tied idle
bind hub75_output tb_led_matrix_sva u_sva_pins (
    .clk_root (clk_root),
    .reset    (reset),
    .bvalid   (1'b0),
    .bready   (1'b1),
    .accept   (1'b0),
    .clk_pixel(pins.clk_pixel),
    .latch    (pins.latch),
    .oe_n     (pins.oe_n)
);
